//--- include/ddr3_phy_cfg.svh
`ifndef DDR3_PHY_CFG_SVH
`define DDR3_PHY_CFG_SVH

// DDR3 command pin widths
`define PHY_ROW_BITS 14 // Row address
`define PHY_BA_BITS 3   // Bank address

// Data lanes
`define PHY_DQ_BITS 8 // DQ bits in one byte lane
`define PHY_LANES 8   // Byte lanes

// Serdes ratio between controller clock and DDR3 clock
`define PHY_SLOTS 4 // Command slots per controller cycle
`define PHY_BEATS 8 // Data beats per controller cycle, both edges

`define PHY_CTRL_CLK_PERIOD_NS 5 // Controller clock in ns

// Delay controller needs 52 ns of reset, rounded up to whole cycles
`define PHY_RST_STRETCH ((52 + `PHY_CTRL_CLK_PERIOD_NS - 1) / `PHY_CTRL_CLK_PERIOD_NS)

// Training reference per lane, bit i is beat i
`define PHY_TRAIN_PATTERN 8'b1111_0000 // Beats 4 to 7 high

`endif

//--- source/ddr3_cmd_pkg.sv
`default_nettype none
`include "ddr3_phy_cfg.svh"

package ddr3_cmd_pkg;

    // One command slot as it goes out on the DDR3 pins
    // Field order follows the bit order of the controller command word
    typedef struct packed {
        logic cs_n;  // Chip select
        logic ras_n; // RAS#
        logic cas_n; // CAS#
        logic we_n;  // WE#
        logic odt;   // On-die termination
        logic cke;   // Clock enable
        logic reset_n; // Memory reset, low while PHY is idle
        logic [`PHY_BA_BITS-1:0] bank;
        logic [`PHY_ROW_BITS-1:0] address; // Row or column address
    } ddr3_cmd_t;

    // All slots of one controller cycle
    // Slot 0 sits in the low bits and is first on the pins
    typedef ddr3_cmd_t [`PHY_SLOTS-1:0] ddr3_cmd_slots_t;

endpackage

`default_nettype wire

//--- source/phy_lane_pkg.sv
`default_nettype none
`include "ddr3_phy_cfg.svh"

package phy_lane_pkg;

    // DQ byte of one lane in one beat
    typedef logic [`PHY_DQ_BITS-1:0] dq_beat_t;

    // Beat group of one lane, beat 0 first in time
    typedef dq_beat_t [`PHY_BEATS-1:0] dq_lane_beats_t;

    // All lanes of one controller cycle
    typedef dq_lane_beats_t [`PHY_LANES-1:0] dq_beats_t;

    // Single-bit beats of one lane
    // Used for DQS and the training reference
    typedef logic [`PHY_BEATS-1:0] strobe_beats_t;

    typedef strobe_beats_t [`PHY_LANES-1:0] strobe_lanes_t; // Per lane strobe groups

    // One bit per byte lane, e.g. bitslip pulses
    typedef logic [`PHY_LANES-1:0] lane_mask_t;

endpackage

`default_nettype wire

//--- source/phy_reset_sync.sv
`timescale 1ns/1ns
`default_nettype none
`include "ddr3_phy_cfg.svh"

module phy_reset_sync (
    input  wire i_controller_clk,
    input  wire i_rst_n,
    output wire o_phy_rst,  // PHY internal reset, active high
    output wire o_phy_ready // Stretched reset is over
);

    localparam int STRETCH = `PHY_RST_STRETCH;
    localparam int CNT_W = $clog2(STRETCH + 1); // Must hold STRETCH itself

    logic [CNT_W-1:0] stretch_cnt; // Cycles left before release
    logic phy_rst_q;

    // Counter is loaded while external reset is low
    // Reset output drops one edge after the counter hits zero
    always_ff @(posedge i_controller_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            stretch_cnt <= CNT_W'(STRETCH);
            phy_rst_q <= 1'b1;
        end else begin
            if (stretch_cnt != '0) begin
                stretch_cnt <= stretch_cnt - 1'b1; // Stops at zero
            end
            phy_rst_q <= (stretch_cnt != '0);
        end
    end

    assign o_phy_rst = phy_rst_q;
    assign o_phy_ready = ~phy_rst_q; // Stands in for the delay controller ready

endmodule

`default_nettype wire

//--- source/phy_tx_path.sv
`timescale 1ns/1ns
`default_nettype none
`include "ddr3_phy_cfg.svh"

module phy_tx_path (
    input  wire i_controller_clk,
    input  wire i_rst_n,
    input  wire i_phy_rst, // Forces idle pins
    input  wire ddr3_cmd_pkg::ddr3_cmd_slots_t i_cmd_slots,
    input  wire phy_lane_pkg::dq_beats_t i_wr_data,
    input  wire i_dq_oe,
    input  wire i_dqs_oe,
    input  wire i_toggle_dqs, // DQS toggles for the whole cycle while high
    output wire ddr3_cmd_pkg::ddr3_cmd_slots_t o_cmd_slots,
    output wire phy_lane_pkg::dq_beats_t o_wr_dq,
    output wire phy_lane_pkg::strobe_lanes_t o_wr_dqs,
    output wire o_dq_oe,
    output wire o_dqs_oe
);

    import ddr3_cmd_pkg::*;
    import phy_lane_pkg::*;

    // Everything that leaves toward the pins in one controller cycle
    typedef struct packed {
        ddr3_cmd_slots_t cmd_slots;
        dq_beats_t wr_dq;
        strobe_lanes_t wr_dqs;
        logic dq_oe;
        logic dqs_oe;
    } tx_pins_t;

    // DQS starts high on beat 0 and alternates
    localparam strobe_beats_t DQS_TOGGLE = {(`PHY_BEATS/2){2'b01}};

    tx_pins_t tx_d;
    tx_pins_t tx_q; // Output register stage

    // All-zero idle keeps cke and reset_n low on the memory
    always_comb begin
        tx_d = '0;
        if (!i_phy_rst) begin
            tx_d.cmd_slots = i_cmd_slots;
            tx_d.wr_dq = i_wr_data;
            tx_d.dq_oe = i_dq_oe;
            tx_d.dqs_oe = i_dqs_oe;
            for (int lane = 0; lane < `PHY_LANES; lane++) begin
                tx_d.wr_dqs[lane] = i_toggle_dqs ? DQS_TOGGLE : '0; // Same pattern every lane
            end
        end
    end

    // Pins go idle at once on external reset
    always_ff @(posedge i_controller_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            tx_q <= '0;
        end else begin
            tx_q <= tx_d;
        end
    end

    assign o_cmd_slots = tx_q.cmd_slots;
    assign o_wr_dq = tx_q.wr_dq;
    assign o_wr_dqs = tx_q.wr_dqs;
    assign o_dq_oe = tx_q.dq_oe;   // High drives DQ
    assign o_dqs_oe = tx_q.dqs_oe; // High drives DQS

endmodule

`default_nettype wire

//--- source/lane_bitslip.sv
`timescale 1ns/1ns
`default_nettype none
`include "ddr3_phy_cfg.svh"

module lane_bitslip #(
    parameter type beat_t = phy_lane_pkg::dq_beat_t // Byte for DQ, logic for strobes
) (
    input  wire i_controller_clk,
    input  wire i_rst_n,
    input  wire i_phy_rst,
    input  wire i_slip, // One pulse slips by one beat
    input  wire beat_t [`PHY_BEATS-1:0] i_beats,
    output beat_t [`PHY_BEATS-1:0] o_beats
);

    localparam int CNT_W = $clog2(`PHY_BEATS);

    logic [CNT_W-1:0] slip_cnt; // Wraps after a full turn
    beat_t [`PHY_BEATS-1:0] rot_beats;

    // Barrel rotate, output beat i takes input beat i+count
    always_comb begin
        for (int i = 0; i < `PHY_BEATS; i++) begin
            rot_beats[i] = i_beats[(i + slip_cnt) % `PHY_BEATS];
        end
    end

    // Output uses the count from before this edge
    // A slip seen at this edge shows from the next cycle on
    always_ff @(posedge i_controller_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            slip_cnt <= '0;
            o_beats <= '0;
        end else if (i_phy_rst) begin
            slip_cnt <= '0; // Slips ignored until ready
            o_beats <= '0;
        end else begin
            slip_cnt <= slip_cnt + CNT_W'(i_slip);
            o_beats <= rot_beats;
        end
    end

endmodule

`default_nettype wire

//--- source/phy_rx_path.sv
`timescale 1ns/1ns
`default_nettype none
`include "ddr3_phy_cfg.svh"

module phy_rx_path (
    input  wire i_controller_clk,
    input  wire i_rst_n,
    input  wire i_phy_rst,
    input  wire phy_lane_pkg::lane_mask_t i_bitslip, // Pulse per lane
    input  wire phy_lane_pkg::dq_beats_t i_rd_dq,      // Captured DQ beats
    input  wire phy_lane_pkg::strobe_lanes_t i_rd_dqs, // Captured DQS beats
    output wire phy_lane_pkg::dq_beats_t o_rd_dq,
    output wire phy_lane_pkg::strobe_lanes_t o_rd_dqs,
    output wire phy_lane_pkg::strobe_lanes_t o_train_ref // Shows the lane slip count
);

    import phy_lane_pkg::*;

    // Known pattern, slipped like the data so training can compare
    localparam strobe_beats_t TRAIN_REF = `PHY_TRAIN_PATTERN;

    // All three slippers of a lane share the same pulse and stay in step
    for (genvar lane = 0; lane < `PHY_LANES; lane++) begin : g_lane

        lane_bitslip #(
            .beat_t(dq_beat_t)
        ) u_dq_slip (
            .i_controller_clk(i_controller_clk),
            .i_rst_n(i_rst_n),
            .i_phy_rst(i_phy_rst),
            .i_slip(i_bitslip[lane]),
            .i_beats(i_rd_dq[lane]),
            .o_beats(o_rd_dq[lane])
        );

        lane_bitslip #(
            .beat_t(logic)
        ) u_dqs_slip (
            .i_controller_clk(i_controller_clk),
            .i_rst_n(i_rst_n),
            .i_phy_rst(i_phy_rst),
            .i_slip(i_bitslip[lane]),
            .i_beats(i_rd_dqs[lane]),
            .o_beats(o_rd_dqs[lane])
        );

        // Fed with the constant instead of captured beats
        lane_bitslip #(
            .beat_t(logic)
        ) u_ref_slip (
            .i_controller_clk(i_controller_clk),
            .i_rst_n(i_rst_n),
            .i_phy_rst(i_phy_rst),
            .i_slip(i_bitslip[lane]),
            .i_beats(TRAIN_REF),
            .o_beats(o_train_ref[lane])
        );
    end

endmodule

`default_nettype wire

//--- source/ddr3_phy_top.sv
`timescale 1ns/1ns
`default_nettype none

module ddr3_phy_top (
    input  wire i_controller_clk,
    input  wire i_rst_n, // External reset, active low
    // Controller side
    input  wire ddr3_cmd_pkg::ddr3_cmd_slots_t i_cmd_slots,
    input  wire phy_lane_pkg::dq_beats_t i_wr_data,
    input  wire i_dq_oe,
    input  wire i_dqs_oe,
    input  wire i_toggle_dqs,
    input  wire phy_lane_pkg::lane_mask_t i_bitslip,
    // Captured beats from the memory side
    input  wire phy_lane_pkg::dq_beats_t i_rd_dq,
    input  wire phy_lane_pkg::strobe_lanes_t i_rd_dqs,
    // Toward the memory pins
    output wire ddr3_cmd_pkg::ddr3_cmd_slots_t o_cmd_slots,
    output wire phy_lane_pkg::dq_beats_t o_wr_dq,
    output wire phy_lane_pkg::strobe_lanes_t o_wr_dqs,
    output wire o_dq_oe,
    output wire o_dqs_oe,
    // Back to the controller
    output wire phy_lane_pkg::dq_beats_t o_rd_dq,
    output wire phy_lane_pkg::strobe_lanes_t o_rd_dqs,
    output wire phy_lane_pkg::strobe_lanes_t o_train_ref,
    output wire o_phy_ready
);

    wire phy_rst; // Stretched reset for both paths

    phy_reset_sync u_reset_sync (
        .i_controller_clk(i_controller_clk),
        .i_rst_n(i_rst_n),
        .o_phy_rst(phy_rst),
        .o_phy_ready(o_phy_ready)
    );

    // Output side
    phy_tx_path u_tx_path (
        .i_controller_clk(i_controller_clk),
        .i_rst_n(i_rst_n),
        .i_phy_rst(phy_rst),
        .i_cmd_slots(i_cmd_slots),
        .i_wr_data(i_wr_data),
        .i_dq_oe(i_dq_oe),
        .i_dqs_oe(i_dqs_oe),
        .i_toggle_dqs(i_toggle_dqs),
        .o_cmd_slots(o_cmd_slots),
        .o_wr_dq(o_wr_dq),
        .o_wr_dqs(o_wr_dqs),
        .o_dq_oe(o_dq_oe),
        .o_dqs_oe(o_dqs_oe)
    );

    // Input side with bitslip
    phy_rx_path u_rx_path (
        .i_controller_clk(i_controller_clk),
        .i_rst_n(i_rst_n),
        .i_phy_rst(phy_rst),
        .i_bitslip(i_bitslip),
        .i_rd_dq(i_rd_dq),
        .i_rd_dqs(i_rd_dqs),
        .o_rd_dq(o_rd_dq),
        .o_rd_dqs(o_rd_dqs),
        .o_train_ref(o_train_ref)
    );

endmodule

`default_nettype wire

//--- tests/tb_clk_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD_NS = 100, // Controller clock period in the testbench
    parameter int RST_CYCLES = 4   // Rising edges with reset held low
) (
    output logic o_controller_clk,
    output logic o_rst_n
);

    initial begin
        o_controller_clk = 1'b0;
        forever #(PERIOD_NS / 2) o_controller_clk = ~o_controller_clk; // First rise at half period
    end

    // Release lines up with the stimulus, a little after the edge
    initial begin
        o_rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge o_controller_clk);
        #10 o_rst_n = 1'b1;
    end

endmodule

`default_nettype wire

//--- tests/tb_ddr3_phy.sv
`timescale 1ns/1ns
`default_nettype none
`include "ddr3_phy_cfg.svh"

module tb_ddr3_phy;

    import ddr3_cmd_pkg::*;
    import phy_lane_pkg::*;

    localparam int PERIOD_NS = 100;
    localparam int RST_CYCLES = 4;
    localparam int STRETCH = `PHY_RST_STRETCH;
    localparam int ROWS = 25; // Table rows after ready
    localparam int TIMEOUT_NS = (RST_CYCLES + STRETCH + ROWS + 10) * PERIOD_NS;
    localparam int CMP_W = $bits(dq_beats_t); // Widest bus that gets compared
    localparam strobe_beats_t TRAIN = `PHY_TRAIN_PATTERN;

    // Inputs of one cycle
    typedef struct packed {
        ddr3_cmd_slots_t cmd_slots;
        dq_beats_t wr_data;
        logic dq_oe;
        logic dqs_oe;
        logic toggle_dqs;
        lane_mask_t bitslip;
        dq_beats_t rd_dq;
        strobe_lanes_t rd_dqs;
    } stim_t;

    // Outputs expected one cycle later
    typedef struct packed {
        ddr3_cmd_slots_t cmd_slots;
        dq_beats_t wr_dq;
        strobe_lanes_t wr_dqs;
        logic dq_oe;
        logic dqs_oe;
        dq_beats_t rd_dq;
        strobe_lanes_t rd_dqs;
        strobe_lanes_t train_ref;
    } resp_t;

    logic clk;
    logic rst_n;
    ddr3_cmd_slots_t cmd_slots;
    dq_beats_t wr_data;
    logic dq_oe;
    logic dqs_oe;
    logic toggle_dqs;
    lane_mask_t bitslip;
    dq_beats_t rd_dq_in;
    strobe_lanes_t rd_dqs_in;
    ddr3_cmd_slots_t out_cmd_slots;
    dq_beats_t out_wr_dq;
    strobe_lanes_t out_wr_dqs;
    logic out_dq_oe;
    logic out_dqs_oe;
    dq_beats_t out_rd_dq;
    strobe_lanes_t out_rd_dqs;
    strobe_lanes_t out_train_ref;
    logic out_phy_ready;

    stim_t stim_tab [ROWS];
    resp_t exp_tab [ROWS];
    int row_test [ROWS]; // Test number of each row
    integer seed = 98;
    int err_cnt = 0;
    int test_err = 0; // Errors in the running test
    int check_cnt = 0;
    int test_cnt = 0;

    tb_clk_gen #(.PERIOD_NS(PERIOD_NS), .RST_CYCLES(RST_CYCLES)) u_clk_gen (
        .o_controller_clk(clk),
        .o_rst_n(rst_n)
    );

    ddr3_phy_top dut0 (
        .i_controller_clk(clk), .i_rst_n(rst_n),
        .i_cmd_slots(cmd_slots), .i_wr_data(wr_data),
        .i_dq_oe(dq_oe), .i_dqs_oe(dqs_oe), .i_toggle_dqs(toggle_dqs),
        .i_bitslip(bitslip), .i_rd_dq(rd_dq_in), .i_rd_dqs(rd_dqs_in),
        .o_cmd_slots(out_cmd_slots), .o_wr_dq(out_wr_dq), .o_wr_dqs(out_wr_dqs),
        .o_dq_oe(out_dq_oe), .o_dqs_oe(out_dqs_oe),
        .o_rd_dq(out_rd_dq), .o_rd_dqs(out_rd_dqs), .o_train_ref(out_train_ref),
        .o_phy_ready(out_phy_ready)
    );

    task automatic compare(input logic [CMP_W-1:0] got, input logic [CMP_W-1:0] exp,
                           input string what);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            test_err++;
            $display("Mismatch at %0t ns: %s got %0h expected %0h", $time, what, got, exp);
        end
    endtask

    function automatic string test_name(input int t);
        case (t)
            0: return "reset and ready";
            1: return "tx passthrough";
            2: return "dqs toggle";
            3: return "rx without slip";
            default: return "bitslip";
        endcase
    endfunction

    task automatic randomize_row(output stim_t s);
        logic [31:0] word;
        for (int i = 0; i < $bits(stim_t); i++) begin
            if (i % 32 == 0) word = $random(seed); // New word every 32 bits
            s[i] = word[i % 32];
        end
    endtask

    task automatic drive_row(input stim_t s);
        cmd_slots = s.cmd_slots;
        wr_data = s.wr_data;
        dq_oe = s.dq_oe;
        dqs_oe = s.dqs_oe;
        toggle_dqs = s.toggle_dqs;
        bitslip = s.bitslip;
        rd_dq_in = s.rd_dq;
        rd_dqs_in = s.rd_dqs;
    endtask

    // Busy inputs that the PHY must ignore while in reset
    task automatic drive_noise();
        stim_t s;
        randomize_row(s);
        s.dq_oe = 1'b1;
        s.dqs_oe = 1'b1;
        s.toggle_dqs = 1'b1;
        s.bitslip = '1; // Slips must not count before ready
        drive_row(s);
    endtask

    // Stimulus rows and their expected outputs from the slip model
    task automatic build_table();
        int cnt [`PHY_LANES];
        stim_t s;
        resp_t e;
        int k;
        for (int lane = 0; lane < `PHY_LANES; lane++) cnt[lane] = 0;
        for (int r = 0; r < ROWS; r++) begin
            randomize_row(s);
            s.bitslip = '0;
            if (r < 4) begin
                row_test[r] = 1;
                s.toggle_dqs = 1'b0;
            end else if (r < 8) begin
                row_test[r] = 2;
                s.toggle_dqs = (r != 5); // On, off, on, on
            end else if (r < 11) begin
                row_test[r] = 3;
            end else begin
                row_test[r] = 4;
                k = r - 11;
                s.bitslip[0] = (k < 8);            // Full turn on lane 0
                s.bitslip[2] = (k == 0 || k == 2); // Lane 2 ends at 2
                s.bitslip[5] = (k == 5);           // Lane 5 ends at 1
            end
            e.cmd_slots = s.cmd_slots;
            e.wr_dq = s.wr_data;
            e.dq_oe = s.dq_oe;
            e.dqs_oe = s.dqs_oe;
            for (int lane = 0; lane < `PHY_LANES; lane++) begin
                for (int i = 0; i < `PHY_BEATS; i++) begin
                    e.wr_dqs[lane][i] = s.toggle_dqs & (i % 2 == 0); // High on even beats
                    e.rd_dq[lane][i] = s.rd_dq[lane][(i + cnt[lane]) % `PHY_BEATS];
                    e.rd_dqs[lane][i] = s.rd_dqs[lane][(i + cnt[lane]) % `PHY_BEATS];
                    e.train_ref[lane][i] = TRAIN[(i + cnt[lane]) % `PHY_BEATS];
                end
                cnt[lane] = (cnt[lane] + s.bitslip[lane]) % `PHY_BEATS; // Counts after this edge
            end
            stim_tab[r] = s;
            exp_tab[r] = e;
        end
    endtask

    task automatic check_idle();
        compare(out_cmd_slots, '0, "o_cmd_slots idle");
        compare(out_wr_dq, '0, "o_wr_dq idle");
        compare(out_wr_dqs, '0, "o_wr_dqs idle");
        compare({out_dq_oe, out_dqs_oe}, '0, "output enables idle");
        compare(out_rd_dq, '0, "o_rd_dq idle");
        compare(out_rd_dqs, '0, "o_rd_dqs idle");
        compare(out_train_ref, '0, "o_train_ref idle");
    endtask

    task automatic check_row(input int r);
        resp_t e;
        e = exp_tab[r];
        compare(out_phy_ready, 1'b1, "o_phy_ready");
        compare(out_cmd_slots, e.cmd_slots, "o_cmd_slots");
        compare(out_wr_dq, e.wr_dq, "o_wr_dq");
        compare(out_wr_dqs, e.wr_dqs, "o_wr_dqs");
        compare(out_dq_oe, e.dq_oe, "o_dq_oe");
        compare(out_dqs_oe, e.dqs_oe, "o_dqs_oe");
        compare(out_rd_dq, e.rd_dq, "o_rd_dq");
        compare(out_rd_dqs, e.rd_dqs, "o_rd_dqs");
        compare(out_train_ref, e.train_ref, "o_train_ref");
    endtask

    task automatic finish_test(input int t);
        $display("Test %0d %s done with %0d errors", t, test_name(t), test_err);
        test_cnt++;
        test_err = 0;
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        build_table();
        drive_noise(); // Inputs busy from time zero
        @(posedge clk);
        #10;
        compare(out_phy_ready, 1'b0, "o_phy_ready in reset");
        check_idle();
        drive_noise();
        @(posedge rst_n);
        // Ready must rise exactly STRETCH+1 edges after release
        for (int e = 1; e <= STRETCH + 1; e++) begin
            @(posedge clk);
            #10;
            compare(out_phy_ready, (e == STRETCH + 1), "o_phy_ready after release");
            check_idle();
            if (e <= STRETCH) drive_noise();
        end
        finish_test(0);
        for (int r = 0; r <= ROWS; r++) begin
            if (r > 0) begin
                @(posedge clk);
                #10;
                check_row(r - 1); // Row driven one cycle ago
                if (r == ROWS || row_test[r] != row_test[r - 1]) finish_test(row_test[r - 1]);
            end
            if (r < ROWS) drive_row(stim_tab[r]);
        end
        $display("Summary: %0d tests, %0d checks, %0d errors", test_cnt, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
+incdir+include
source/ddr3_cmd_pkg.sv
source/phy_lane_pkg.sv
source/phy_reset_sync.sv
source/phy_tx_path.sv
source/lane_bitslip.sv
source/phy_rx_path.sv
source/ddr3_phy_top.sv
tests/tb_clk_gen.sv
tests/tb_ddr3_phy.sv

//--- Bender.yml
package:
  name: ddr3_phy

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/ddr3_cmd_pkg.sv
      - source/phy_lane_pkg.sv
      - source/phy_reset_sync.sv
      - source/phy_tx_path.sv
      - source/lane_bitslip.sv
      - source/phy_rx_path.sv
      - source/ddr3_phy_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/tb_clk_gen.sv
      - tests/tb_ddr3_phy.sv
